//--- source/icache_pkg.sv
package icache_pkg;

  // address and data widths on both the fetch side and AXI
  localparam int ADDR_WIDTH = 32;
  localparam int WORD_WIDTH = 32;

  // line geometry
  localparam int LINE_WORDS    = 4;
  localparam int OFFSET_BITS   = 4;                        // byte offset within a line
  localparam int WORD_SEL_BITS = $clog2(LINE_WORDS);       // word index within a line
  localparam int BYTE_BITS     = OFFSET_BITS - WORD_SEL_BITS;

  // AXI read length field
  localparam int LEN_WIDTH = 8;
  localparam logic [LEN_WIDTH-1:0] SINGLE_LEN = 8'd0;      // one beat
  localparam logic [LEN_WIDTH-1:0] BURST_LEN  = 8'd3;      // four beats, whole line

  // how a request is served, picked from its address region
  typedef enum logic [1:0] {
    fill_bypass,   // uncached, single read, nothing stored
    fill_burst,    // one wrapping burst
    fill_single    // flash, four single reads
  } fill_kind_e;

endpackage

//--- source/icache_way.sv
`timescale 1ns/10ps

module icache_way #(
  parameter int INDEX_BITS = 4,
  parameter int TAG_BITS   = 24
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [INDEX_BITS-1:0] index,
  input  logic                  write_enable,
  input  logic [TAG_BITS-1:0]   write_tag,
  input  logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_WIDTH-1:0] write_line,
  input  logic                  invalidate_all,
  output logic                  valid,
  output logic [TAG_BITS-1:0]   tag,
  output logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_WIDTH-1:0] line
);

  localparam int SETS = 1 << INDEX_BITS;

  logic [SETS-1:0]     valid_bits;
  logic [TAG_BITS-1:0] tags [SETS];
  logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_WIDTH-1:0] lines [SETS];

  always_ff @(posedge clock) begin
    if (reset || invalidate_all) begin  // fencei wins over a fill write
      valid_bits <= '0;
    end else if (write_enable) begin
      valid_bits[index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (write_enable) begin
      tags[index]  <= write_tag;
      lines[index] <= write_line;
    end
  end

  // combinational lookup
  assign valid = valid_bits[index];
  assign tag   = tags[index];
  assign line  = lines[index];

endmodule

//--- source/icache_ctrl.sv
`timescale 1ns/10ps

module icache_ctrl #(
  parameter int INDEX_BITS = 4,
  parameter logic [icache_pkg::ADDR_WIDTH-1:0] UNCACHED_LIMIT = 32'h3000_0000,
  parameter logic [icache_pkg::ADDR_WIDTH-1:0] BURST_BASE     = 32'ha000_0000
) (
  input  logic clock,
  input  logic reset,

  input  logic                              fetch_valid,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] fetch_addr,
  output logic                              fetch_ready,
  output logic                              resp_valid,
  output logic [icache_pkg::WORD_WIDTH-1:0] resp_data,
  input  logic                              fencei,

  output logic                              ar_valid,
  input  logic                              ar_ready,
  output logic [icache_pkg::ADDR_WIDTH-1:0] ar_addr,
  output logic [icache_pkg::LEN_WIDTH-1:0]  ar_len,
  input  logic                              r_valid,
  input  logic [icache_pkg::WORD_WIDTH-1:0] r_data,
  input  logic                              r_last,
  output logic                              r_ready,

  output logic [INDEX_BITS-1:0] index,

  input  logic                                                          way0_valid,
  input  logic [icache_pkg::ADDR_WIDTH-INDEX_BITS-icache_pkg::OFFSET_BITS-1:0] way0_tag,
  input  logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_WIDTH-1:0] way0_line,
  input  logic                                                          way1_valid,
  input  logic [icache_pkg::ADDR_WIDTH-INDEX_BITS-icache_pkg::OFFSET_BITS-1:0] way1_tag,
  input  logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_WIDTH-1:0] way1_line,

  output logic                                                          way0_write,
  output logic                                                          way1_write,
  output logic [icache_pkg::ADDR_WIDTH-INDEX_BITS-icache_pkg::OFFSET_BITS-1:0] write_tag,
  output logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_WIDTH-1:0] write_line,
  output logic                                                          invalidate_all
);

  localparam int TAG_LSB  = icache_pkg::OFFSET_BITS + INDEX_BITS;
  localparam int TAG_BITS = icache_pkg::ADDR_WIDTH - TAG_LSB;
  localparam int SETS     = 1 << INDEX_BITS;
  localparam int WSB      = icache_pkg::WORD_SEL_BITS;

  typedef enum logic [2:0] {
    idle,
    bypass,
    burst,
    single_request,
    single_wait
  } state_e;

  state_e state;

  logic [icache_pkg::ADDR_WIDTH-1:0] req_addr;  // accepted miss address
  icache_pkg::fill_kind_e            req_kind;
  icache_pkg::fill_kind_e            fetch_kind;
  logic [SETS-1:0]                   replace_bits;  // way to fill next, per set
  logic [WSB-1:0]                    beat_count;
  logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_WIDTH-1:0] line_buf;
  logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_WIDTH-1:0] fill_line;

  logic [INDEX_BITS-1:0] fetch_index;
  logic [INDEX_BITS-1:0] req_index;
  logic [TAG_BITS-1:0]   fetch_tag;
  logic [WSB-1:0]        fetch_word;
  logic [WSB-1:0]        req_word;
  logic [WSB-1:0]        beat_pos;
  logic [WSB-1:0]        next_pos;
  logic                  accept;
  logic                  hit0;
  logic                  hit1;
  logic                  fetch_hit;
  logic                  beat;
  logic                  final_beat;
  logic                  fill_write;

  assign fetch_index = fetch_addr[TAG_LSB-1:icache_pkg::OFFSET_BITS];
  assign fetch_tag   = fetch_addr[icache_pkg::ADDR_WIDTH-1:TAG_LSB];
  assign fetch_word  = fetch_addr[icache_pkg::OFFSET_BITS-1:icache_pkg::BYTE_BITS];
  assign req_index   = req_addr[TAG_LSB-1:icache_pkg::OFFSET_BITS];
  assign req_word    = req_addr[icache_pkg::OFFSET_BITS-1:icache_pkg::BYTE_BITS];

  // region classification
  always_comb begin
    if (fetch_addr < UNCACHED_LIMIT) begin
      fetch_kind = icache_pkg::fill_bypass;
    end else if (fetch_addr >= BURST_BASE) begin
      fetch_kind = icache_pkg::fill_burst;
    end else begin
      fetch_kind = icache_pkg::fill_single;
    end
  end

  assign fetch_ready = (state == idle);
  assign accept      = fetch_valid && fetch_ready;
  assign index       = (state == idle) ? fetch_index : req_index;

  assign hit0      = way0_valid && (way0_tag == fetch_tag);
  assign hit1      = way1_valid && (way1_tag == fetch_tag);
  assign fetch_hit = (fetch_kind != icache_pkg::fill_bypass) && (hit0 || hit1);

  assign r_ready = (state == bypass) || (state == burst) || (state == single_wait);
  assign beat    = r_valid && r_ready;

  assign beat_pos = req_word + beat_count;  // wraps within the line
  assign next_pos = beat_pos + 1'b1;

  always_comb begin
    case (state)
      bypass:      final_beat = beat;
      burst:       final_beat = beat && r_last;
      single_wait: final_beat = beat && (beat_count == WSB'(icache_pkg::LINE_WORDS - 1));
      default:     final_beat = 1'b0;
    endcase
  end

  // last beat goes straight into the way, merged with the buffered ones
  always_comb begin
    fill_line           = line_buf;
    fill_line[beat_pos] = r_data;
  end

  assign fill_write     = final_beat && (req_kind != icache_pkg::fill_bypass);
  assign way0_write     = fill_write && !replace_bits[req_index];
  assign way1_write     = fill_write && replace_bits[req_index];
  assign write_tag      = req_addr[icache_pkg::ADDR_WIDTH-1:TAG_LSB];
  assign write_line     = fill_line;
  assign invalidate_all = fencei && fetch_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= idle;
      ar_valid     <= 1'b0;
      resp_valid   <= 1'b0;
      beat_count   <= '0;
      replace_bits <= '0;
    end else begin
      resp_valid <= 1'b0;
      case (state)
        idle: begin
          if (accept) begin
            if (fetch_hit) begin
              resp_valid                <= 1'b1;
              replace_bits[fetch_index] <= hit0;  // point away from the hit way
            end else begin
              ar_valid   <= 1'b1;
              beat_count <= '0;
              case (fetch_kind)
                icache_pkg::fill_bypass: state <= bypass;
                icache_pkg::fill_burst:  state <= burst;
                default:                 state <= single_request;
              endcase
            end
          end
        end
        bypass, burst: begin
          if (ar_valid && ar_ready) begin
            ar_valid <= 1'b0;
          end
          if (final_beat) begin
            state <= idle;
          end
        end
        single_request: begin
          if (ar_ready) begin
            ar_valid <= 1'b0;
            state    <= single_wait;
          end
        end
        single_wait: begin
          if (final_beat) begin
            state <= idle;
          end else if (beat) begin
            ar_valid <= 1'b1;  // next word of the line
            state    <= single_request;
          end
        end
        default: state <= idle;
      endcase

      if (beat) begin
        beat_count <= beat_count + 1'b1;
        if (beat_count == '0) begin
          resp_valid <= 1'b1;  // requested word comes first
        end
      end
      if (fill_write) begin
        replace_bits[req_index] <= ~replace_bits[req_index];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == idle && accept) begin
      req_addr  <= fetch_addr;
      req_kind  <= fetch_kind;
      ar_addr   <= fetch_addr;
      ar_len    <= (fetch_kind == icache_pkg::fill_burst) ? icache_pkg::BURST_LEN
                                                          : icache_pkg::SINGLE_LEN;
      resp_data <= hit1 ? way1_line[fetch_word] : way0_line[fetch_word];
    end
    if (beat) begin
      line_buf[beat_pos] <= r_data;
      if (beat_count == '0) begin
        resp_data <= r_data;
      end
    end
    if (state == single_wait && beat && !final_beat) begin
      ar_addr <= {req_addr[icache_pkg::ADDR_WIDTH-1:icache_pkg::OFFSET_BITS], next_pos,
                  {icache_pkg::BYTE_BITS{1'b0}}};
    end
  end

endmodule

//--- source/icache_top.sv
`timescale 1ns/10ps

module icache_top #(
  parameter int INDEX_BITS = 4,
  parameter logic [icache_pkg::ADDR_WIDTH-1:0] UNCACHED_LIMIT = 32'h3000_0000,
  parameter logic [icache_pkg::ADDR_WIDTH-1:0] BURST_BASE     = 32'ha000_0000
) (
  input  logic clock,
  input  logic reset,

  input  logic                              fetch_valid,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] fetch_addr,
  output logic                              fetch_ready,
  output logic                              resp_valid,
  output logic [icache_pkg::WORD_WIDTH-1:0] resp_data,
  input  logic                              fencei,

  output logic                              ar_valid,
  input  logic                              ar_ready,
  output logic [icache_pkg::ADDR_WIDTH-1:0] ar_addr,
  output logic [icache_pkg::LEN_WIDTH-1:0]  ar_len,
  input  logic                              r_valid,
  input  logic [icache_pkg::WORD_WIDTH-1:0] r_data,
  input  logic                              r_last,
  output logic                              r_ready
);

  localparam int TAG_BITS = icache_pkg::ADDR_WIDTH - INDEX_BITS - icache_pkg::OFFSET_BITS;

  logic [INDEX_BITS-1:0] index;
  logic                  way0_valid;
  logic                  way1_valid;
  logic [TAG_BITS-1:0]   way0_tag;
  logic [TAG_BITS-1:0]   way1_tag;
  logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_WIDTH-1:0] way0_line;
  logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_WIDTH-1:0] way1_line;
  logic                  way0_write;
  logic                  way1_write;
  logic [TAG_BITS-1:0]   write_tag;
  logic [icache_pkg::LINE_WORDS-1:0][icache_pkg::WORD_WIDTH-1:0] write_line;
  logic                  invalidate_all;

  icache_ctrl #(
    .INDEX_BITS     (INDEX_BITS),
    .UNCACHED_LIMIT (UNCACHED_LIMIT),
    .BURST_BASE     (BURST_BASE)
  ) controller (
    .clock, .reset,
    .fetch_valid, .fetch_addr, .fetch_ready, .resp_valid, .resp_data, .fencei,
    .ar_valid, .ar_ready, .ar_addr, .ar_len, .r_valid, .r_data, .r_last, .r_ready,
    .index,
    .way0_valid, .way0_tag, .way0_line, .way1_valid, .way1_tag, .way1_line,
    .way0_write, .way1_write, .write_tag, .write_line, .invalidate_all
  );

  icache_way #(
    .INDEX_BITS (INDEX_BITS),
    .TAG_BITS   (TAG_BITS)
  ) way0 (
    .clock, .reset, .index,
    .write_enable   (way0_write),
    .write_tag, .write_line, .invalidate_all,
    .valid          (way0_valid),
    .tag            (way0_tag),
    .line           (way0_line)
  );

  icache_way #(
    .INDEX_BITS (INDEX_BITS),
    .TAG_BITS   (TAG_BITS)
  ) way1 (
    .clock, .reset, .index,
    .write_enable   (way1_write),
    .write_tag, .write_line, .invalidate_all,
    .valid          (way1_valid),
    .tag            (way1_tag),
    .line           (way1_line)
  );

endmodule

//--- tests/axi_mem_model.sv
`timescale 1ns/10ps

module axi_mem_model (
  input  logic        clock,
  input  logic        reset,
  input  logic        ar_valid,
  output logic        ar_ready,
  input  logic [31:0] ar_addr,
  input  logic [7:0]  ar_len,
  output logic        r_valid,
  output logic [31:0] r_data,
  output logic        r_last,
  input  logic        r_ready
);

  localparam int READY_LIMIT = 50;  // cycles a beat may wait for r_ready

  integer seed;
  int     request_count;  // address handshakes seen
  int     len_total;      // sum of ar_len over those requests
  bit     stuck;

  // inverted address, rotated left by 8
  function automatic logic [31:0] image_word(input logic [31:0] addr);
    logic [31:0] inverted;
    inverted = ~addr;
    return {inverted[23:0], inverted[31:24]};
  endfunction

  task automatic stall_cycles();
    logic [31:0] rnd;
    rnd = $random(seed);
    repeat (rnd[1:0]) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic serve_request();
    logic [31:0] addr;
    logic [7:0]  len;
    logic [1:0]  word_sel;
    int          beat;
    int          waited;
    bit          taken;
    stall_cycles();
    addr = ar_addr;
    len = ar_len;
    ar_ready = 1'b1;
    request_count++;
    len_total += int'(len);
    @(posedge clock);
    #1;
    ar_ready = 1'b0;
    for (beat = 0; beat <= int'(len) && !stuck; beat++) begin
      stall_cycles();
      word_sel = addr[3:2] + beat[1:0];  // wraps within the line
      r_valid = 1'b1;
      r_data = image_word({addr[31:4], word_sel, 2'b00});
      r_last = (beat == int'(len));
      taken = 1'b0;
      waited = 0;
      while (!taken && waited < READY_LIMIT) begin
        taken = r_ready;
        @(posedge clock);
        #1;
        waited++;
      end
      r_valid = 1'b0;
      r_last = 1'b0;
      if (!taken) begin
        stuck = 1'b1;
        $display("memory model: a read beat was not accepted within %0d cycles", READY_LIMIT);
      end
    end
  endtask

  initial begin
    seed = 32'h44a5_23c6;
    request_count = 0;
    len_total = 0;
    stuck = 1'b0;
    ar_ready = 1'b0;
    r_valid = 1'b0;
    r_data = '0;
    r_last = 1'b0;
    forever begin
      @(posedge clock);
      #1;
      if (!reset && ar_valid && !stuck) begin
        serve_request();
      end
    end
  end

endmodule

//--- tests/icache_assertions.sv
`timescale 1ns/10ps

module icache_assertions #(
  parameter logic [icache_pkg::ADDR_WIDTH-1:0] UNCACHED_LIMIT = 32'h3000_0000
) (
  input logic                              clock,
  input logic                              reset,
  input logic                              fetch_valid,
  input logic                              ar_valid,
  input logic                              ar_ready,
  input logic [icache_pkg::ADDR_WIDTH-1:0] ar_addr,
  input logic                              resp_valid,
  input logic                              fetch_ready,
  input logic                              way0_write,
  input logic                              way1_write
);

  ar_hold: assert property (@(posedge clock) disable iff (reset)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
    else $error("ar_valid dropped or ar_addr changed before ar_ready");

  // back-to-back hits give one response per accepted request
  resp_pulse: assert property (@(posedge clock) disable iff (reset)
    resp_valid && !(fetch_valid && fetch_ready) |=> !resp_valid)
    else $error("resp_valid held high without a new request");

  // idle values one cycle into reset
  reset_values: assert property (@(posedge clock)
    reset |=> !ar_valid && !resp_valid && fetch_ready)
    else $error("wrong handshake outputs after reset");

  // ar_addr still points into the requested line on the final beat
  bypass_no_write: assert property (@(posedge clock) disable iff (reset)
    (way0_write || way1_write) |-> ar_addr >= UNCACHED_LIMIT)
    else $error("way written for a bypass request");

endmodule

bind icache_ctrl icache_assertions #(
  .UNCACHED_LIMIT (UNCACHED_LIMIT)
) checks (
  .clock       (clock),
  .reset       (reset),
  .fetch_valid (fetch_valid),
  .ar_valid    (ar_valid),
  .ar_ready    (ar_ready),
  .ar_addr     (ar_addr),
  .resp_valid  (resp_valid),
  .fetch_ready (fetch_ready),
  .way0_write  (way0_write),
  .way1_write  (way1_write)
);

//--- tests/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;

  localparam int WAIT_LIMIT = 200;  // cycles per wait

  logic        clock;
  logic        reset;
  logic        fetch_valid;
  logic [31:0] fetch_addr;
  logic        fetch_ready;
  logic        resp_valid;
  logic [31:0] resp_data;
  logic        fencei;
  logic        ar_valid;
  logic        ar_ready;
  logic [31:0] ar_addr;
  logic [7:0]  ar_len;
  logic        r_valid;
  logic [31:0] r_data;
  logic        r_last;
  logic        r_ready;

  // stimulus table, one entry per test
  string       row_name[$];
  logic [31:0] row_addr[$];
  bit          row_fencei[$];
  int          row_requests[$];
  int          row_len[$];
  bit          row_data[$];

  int errors;
  int tests_ok;
  bit timed_out;

  icache_top #(
    .INDEX_BITS     (4),
    .UNCACHED_LIMIT (32'h3000_0000),
    .BURST_BASE     (32'ha000_0000)
  ) UUT (
    .clock, .reset,
    .fetch_valid, .fetch_addr, .fetch_ready, .resp_valid, .resp_data, .fencei,
    .ar_valid, .ar_ready, .ar_addr, .ar_len, .r_valid, .r_data, .r_last, .r_ready
  );

  axi_mem_model memory (
    .clock, .reset,
    .ar_valid, .ar_ready, .ar_addr, .ar_len, .r_valid, .r_data, .r_last, .r_ready
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [31:0] inverted;
    inverted = ~{addr[31:2], 2'b00};
    return {inverted[23:0], inverted[31:24]};
  endfunction

  task automatic add_row(input string name, input logic [31:0] addr, input bit fence,
                         input int requests, input int len, input bit check_data);
    row_name.push_back(name);
    row_addr.push_back(addr);
    row_fencei.push_back(fence);
    row_requests.push_back(requests);
    row_len.push_back(len);
    row_data.push_back(check_data);
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic wait_ready(input string name, output bit seen);
    int waited;
    waited = 0;
    while (!fetch_ready && waited < WAIT_LIMIT) begin
      next_cycle();
      waited++;
    end
    seen = fetch_ready;
    if (!seen) $display("fetch_ready stayed low for %0d cycles in %s", WAIT_LIMIT, name);
  endtask

  task automatic wait_response(input string name, output bit seen);
    int waited;
    waited = 0;
    while (!resp_valid && waited < WAIT_LIMIT) begin
      next_cycle();
      waited++;
    end
    seen = resp_valid;
    if (!seen) $display("no response arrived within %0d cycles in %s", WAIT_LIMIT, name);
  endtask

  task automatic run_row(input int i);
    int          req_before;
    int          len_before;
    int          errors_before;
    bit          seen;
    logic [31:0] expected;
    errors_before = errors;
    req_before = memory.request_count;
    len_before = memory.len_total;
    wait_ready(row_name[i], seen);
    if (seen && row_fencei[i]) begin
      fencei = 1'b1;
      next_cycle();
      fencei = 1'b0;
    end else if (seen) begin
      fetch_addr = row_addr[i];
      fetch_valid = 1'b1;
      next_cycle();
      fetch_valid = 1'b0;
    end
    if (seen && row_data[i]) begin
      wait_response(row_name[i], seen);
      expected = expected_word(row_addr[i]);
      if (seen) begin
        assert (resp_data == expected) else begin
          $display("CHECK FAILED %s: resp_data expected %h actual %h",
                   row_name[i], expected, resp_data);
          errors++;
        end
      end
    end
    if (seen) wait_ready(row_name[i], seen);  // rest of a fill
    if (seen) begin
      assert (memory.request_count - req_before == row_requests[i]) else begin
        $display("CHECK FAILED %s: requests expected %0d actual %0d", row_name[i],
                 row_requests[i], memory.request_count - req_before);
        errors++;
      end
      assert (memory.len_total - len_before == row_requests[i] * row_len[i]) else begin
        $display("CHECK FAILED %s: summed ar_len expected %0d actual %0d", row_name[i],
                 row_requests[i] * row_len[i], memory.len_total - len_before);
        errors++;
      end
    end
    if (!seen) begin
      timed_out = 1'b1;
      $display("%s: timed out", row_name[i]);
    end else if (errors == errors_before) begin
      tests_ok++;
      $display("%s: ok", row_name[i]);
    end else begin
      $display("%s: mismatch", row_name[i]);
    end
  endtask

  task automatic fill_table();
    add_row("burst_miss",      32'ha000_0148, 0, 1, 3, 1);
    add_row("burst_hit_w0",    32'ha000_0140, 0, 0, 0, 1);
    add_row("burst_hit_w1",    32'ha000_0144, 0, 0, 0, 1);
    add_row("burst_hit_w3",    32'ha000_014c, 0, 0, 0, 1);
    add_row("single_miss",     32'h4000_0234, 0, 4, 0, 1);
    add_row("single_hit_w0",   32'h4000_0230, 0, 0, 0, 1);
    add_row("single_hit_w1",   32'h4000_0234, 0, 0, 0, 1);
    add_row("single_hit_w2",   32'h4000_0238, 0, 0, 0, 1);
    add_row("single_hit_w3",   32'h4000_023c, 0, 0, 0, 1);
    add_row("bypass_first",    32'h1000_0010, 0, 1, 0, 1);
    add_row("bypass_again",    32'h1000_0010, 0, 1, 0, 1);
    add_row("repl_fill_a",     32'ha000_0050, 0, 1, 3, 1);  // set 5, three tags
    add_row("repl_fill_b",     32'ha000_1058, 0, 1, 3, 1);
    add_row("repl_hit_a",      32'ha000_0050, 0, 0, 0, 1);
    add_row("repl_fill_c",     32'ha000_205c, 0, 1, 3, 1);
    add_row("repl_a_kept",     32'ha000_0054, 0, 0, 0, 1);
    add_row("repl_b_evicted",  32'ha000_1058, 0, 1, 3, 1);
    add_row("fencei_pulse",    32'h0000_0000, 1, 0, 0, 0);
    add_row("fencei_burst",    32'ha000_0144, 0, 1, 3, 1);
    add_row("fencei_single",   32'h4000_0238, 0, 4, 0, 1);
  endtask

  initial begin
    int i;
    reset = 1'b1;
    fetch_valid = 1'b0;
    fetch_addr = '0;
    fencei = 1'b0;
    errors = 0;
    tests_ok = 0;
    timed_out = 1'b0;
    fill_table();
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;
    for (i = 0; i < row_name.size() && !timed_out; i++) begin
      run_row(i);
    end
    $display("%0d of %0d tests ok, %0d check errors", tests_ok, row_name.size(), errors);
    if (errors == 0 && !timed_out && !memory.stuck && tests_ok == row_name.size()) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- build.f
source/icache_pkg.sv
source/icache_way.sv
source/icache_ctrl.sv
source/icache_top.sv
tests/axi_mem_model.sv
tests/icache_assertions.sv
tests/icache_tb.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the icache testbench

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
    -Mdir obj_dir -f build.f; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vicache_tb > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi
cat sim.log

if grep -qx "all tests passed" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
